// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - design/core_pkg.sv
      - design/rv_decoder.sv
      - design/rv_alu.sv
      - design/rv_branch_unit.sv
      - design/rv_regfile.sv
      - design/rv_lsu.sv
      - design/rv_core.sv
  - target: test
    files:
      - test/rv_core_properties.sv
      - test/tb_rv_core.sv

// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs = 32;
  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // major opcodes in instr[6:0]
  typedef enum logic [6:0] {
    opc_op     = 7'b011_0011,
    opc_op_imm = 7'b001_0011,
    opc_load   = 7'b000_0011,
    opc_store  = 7'b010_0011,
    opc_branch = 7'b110_0011,
    opc_jal    = 7'b110_1111,
    opc_jalr   = 7'b110_0111,
    opc_lui    = 7'b011_0111,
    opc_auipc  = 7'b001_0111,
    opc_system = 7'b111_0011
  } opcode_e;

  // funct3 of OP / OP_IMM
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3 of BRANCH
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // LOAD / STORE access size where the _u codes exist for loads only
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [2:0] {
    wb_alu, wb_load, wb_pc_plus4, wb_imm, wb_pc_target
  } wb_sel_e;

  typedef struct packed {
    alu_op_e         alu_op;
    logic            alu_src_imm; // b operand from imm instead of rs2
    wb_sel_e         wb_sel;
    logic            reg_we;
    logic            mem_re;
    logic            mem_we;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm;        // operand immediate
    logic [xlen-1:0] target_imm; // pc adder immediate
  } ctrl_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0]      wmask; // one bit per byte lane
    logic            we;
    logic            re;
  } dmem_req_t;

endpackage

`default_nettype wire

// File: design/rv_alu.sv
`default_nettype none

module rv_alu (
  input  core_pkg::alu_op_e          op,
  input  logic [core_pkg::xlen-1:0]  a,
  input  logic [core_pkg::xlen-1:0]  b,
  output logic [core_pkg::xlen-1:0]  result
);

  logic [core_pkg::xlen:0] diff; // extra msb is the borrow
  logic [4:0] shamt;
  logic lt_signed;
  logic lt_unsigned;

  assign diff  = {1'b0, a} - {1'b0, b};
  assign shamt = b[4:0];

  assign lt_unsigned = diff[core_pkg::xlen];
  // on differing signs the sign of a decides, otherwise the difference does
  assign lt_signed = (a[core_pkg::xlen-1] ^ b[core_pkg::xlen-1]) ?
                     a[core_pkg::xlen-1] : diff[core_pkg::xlen-1];

  always_comb begin
    case (op)
      core_pkg::alu_add:  result = a + b;
      core_pkg::alu_sub:  result = diff[core_pkg::xlen-1:0];
      core_pkg::alu_sll:  result = a << shamt;
      core_pkg::alu_slt:  result = {{(core_pkg::xlen-1){1'b0}}, lt_signed};
      core_pkg::alu_sltu: result = {{(core_pkg::xlen-1){1'b0}}, lt_unsigned};
      core_pkg::alu_xor:  result = a ^ b;
      core_pkg::alu_srl:  result = a >> shamt;
      core_pkg::alu_sra:  result = $signed(a) >>> shamt;
      core_pkg::alu_or:   result = a | b;
      core_pkg::alu_and:  result = a & b;
      default:            result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_branch_unit.sv
`default_nettype none

module rv_branch_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  core_pkg::ctrl_t           ctrl,
  input  logic [core_pkg::xlen-1:0] rs1_data,
  input  logic [core_pkg::xlen-1:0] rs2_data,
  output logic [core_pkg::xlen-1:0] pc,
  output logic [core_pkg::xlen-1:0] pc_target
);

  logic [core_pkg::xlen:0] cmp_diff;
  logic is_eq;
  logic is_lt;
  logic is_ltu;
  logic cond;
  logic taken;
  logic [core_pkg::xlen-1:0] base;
  logic [core_pkg::xlen-1:0] sum;
  logic [core_pkg::xlen-1:0] pc_next;

  // comparator for the six branch conditions
  assign cmp_diff = {1'b0, rs1_data} - {1'b0, rs2_data};
  assign is_eq    = (cmp_diff[core_pkg::xlen-1:0] == '0);
  assign is_ltu   = cmp_diff[core_pkg::xlen];
  assign is_lt    = (rs1_data[core_pkg::xlen-1] ^ rs2_data[core_pkg::xlen-1]) ?
                    rs1_data[core_pkg::xlen-1] : cmp_diff[core_pkg::xlen-1];

  always_comb begin
    case (ctrl.funct3)
      core_pkg::f3_beq:  cond = is_eq;
      core_pkg::f3_bne:  cond = ~is_eq;
      core_pkg::f3_blt:  cond = is_lt;
      core_pkg::f3_bge:  cond = ~is_lt;
      core_pkg::f3_bltu: cond = is_ltu;
      core_pkg::f3_bgeu: cond = ~is_ltu;
      default:           cond = 1'b0;
    endcase
  end

  // jalr adds to rs1, everything else to pc
  assign base = ctrl.is_jalr ? rs1_data : pc;
  assign sum  = base + ctrl.target_imm;
  assign pc_target = ctrl.is_jalr ? {sum[core_pkg::xlen-1:1], 1'b0} : sum;

  assign taken   = ctrl.is_jal | ctrl.is_jalr | (ctrl.is_branch & cond);
  assign pc_next = taken ? pc_target : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= core_pkg::reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// File: design/rv_core.sv
`default_nettype none

module rv_core (
  input  logic                      clk,
  input  logic                      rst,
  output logic [core_pkg::xlen-1:0] pc,
  input  logic [core_pkg::xlen-1:0] instr,
  output core_pkg::dmem_req_t       dmem_req,
  input  logic [core_pkg::xlen-1:0] dmem_rdata
);

  core_pkg::ctrl_t ctrl;
  core_pkg::dmem_req_t lsu_req;
  logic [core_pkg::reg_addr_w-1:0] rs1;
  logic [core_pkg::reg_addr_w-1:0] rs2;
  logic [core_pkg::reg_addr_w-1:0] rd;
  logic [core_pkg::xlen-1:0] rs1_data;
  logic [core_pkg::xlen-1:0] rs2_data;
  logic [core_pkg::xlen-1:0] alu_b;
  logic [core_pkg::xlen-1:0] alu_result;
  logic [core_pkg::xlen-1:0] pc_target;
  logic [core_pkg::xlen-1:0] load_data;
  logic [core_pkg::xlen-1:0] wb_data;
  logic reg_we;

  rv_decoder u_decoder (
    .instr (instr),
    .ctrl  (ctrl),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd)
  );

  assign reg_we = ctrl.reg_we & ~rst;

  rv_regfile u_regfile (
    .clk    (clk),
    .we     (reg_we),
    .waddr  (rd),
    .wdata  (wb_data),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  assign alu_b = ctrl.alu_src_imm ? ctrl.imm : rs2_data;

  rv_alu u_alu (
    .op     (ctrl.alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_result)
  );

  rv_branch_unit u_branch (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .pc        (pc),
    .pc_target (pc_target)
  );

  rv_lsu u_lsu (
    .ctrl       (ctrl),
    .addr       (alu_result), // rs1 + imm
    .store_data (rs2_data),
    .rdata      (dmem_rdata),
    .req        (lsu_req),
    .load_data  (load_data)
  );

  // memory strobes held low while in reset
  always_comb begin
    dmem_req = lsu_req;
    dmem_req.we = lsu_req.we & ~rst;
    dmem_req.re = lsu_req.re & ~rst;
    if (rst) begin
      dmem_req.wmask = 4'b0000;
    end
  end

  always_comb begin
    case (ctrl.wb_sel)
      core_pkg::wb_alu:       wb_data = alu_result;
      core_pkg::wb_load:      wb_data = load_data;
      core_pkg::wb_pc_plus4:  wb_data = pc + 32'd4; // return address
      core_pkg::wb_imm:       wb_data = ctrl.imm;
      core_pkg::wb_pc_target: wb_data = pc_target;
      default:                wb_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_decoder.sv
`default_nettype none

module rv_decoder (
  input  logic [core_pkg::xlen-1:0]       instr,
  output core_pkg::ctrl_t                 ctrl,
  output logic [core_pkg::reg_addr_w-1:0] rs1,
  output logic [core_pkg::reg_addr_w-1:0] rs2,
  output logic [core_pkg::reg_addr_w-1:0] rd
);

  core_pkg::opcode_e opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic alt_sub;
  core_pkg::alu_op_e arith_op;

  logic [core_pkg::xlen-1:0] imm_i;
  logic [core_pkg::xlen-1:0] imm_s;
  logic [core_pkg::xlen-1:0] imm_b;
  logic [core_pkg::xlen-1:0] imm_u;
  logic [core_pkg::xlen-1:0] imm_j;
  logic [core_pkg::xlen-1:0] shamt_imm;

  assign opcode = core_pkg::opcode_e'(instr[6:0]);
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign shamt_imm = {{(core_pkg::xlen-5){1'b0}}, instr[24:20]};

  // sub only exists in register form, addi has no funct7
  assign alt_sub = (opcode == core_pkg::opc_op) & funct7[5];

  always_comb begin
    case (funct3)
      core_pkg::f3_add_sub: arith_op = alt_sub ? core_pkg::alu_sub : core_pkg::alu_add;
      core_pkg::f3_sll:     arith_op = core_pkg::alu_sll;
      core_pkg::f3_slt:     arith_op = core_pkg::alu_slt;
      core_pkg::f3_sltu:    arith_op = core_pkg::alu_sltu;
      core_pkg::f3_xor:     arith_op = core_pkg::alu_xor;
      core_pkg::f3_srl_sra: arith_op = funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
      core_pkg::f3_or:      arith_op = core_pkg::alu_or;
      core_pkg::f3_and:     arith_op = core_pkg::alu_and;
      default:              arith_op = core_pkg::alu_add;
    endcase
  end

  always_comb begin
    ctrl = '0; // no writes unless the opcode asks
    ctrl.alu_op = core_pkg::alu_add;
    ctrl.wb_sel = core_pkg::wb_alu;
    ctrl.funct3 = funct3;
    case (opcode)
      core_pkg::opc_op: begin
        ctrl.alu_op = arith_op;
        ctrl.reg_we = 1'b1;
      end
      core_pkg::opc_op_imm: begin
        ctrl.alu_op = arith_op;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_we = 1'b1;
        if (funct3 == core_pkg::f3_sll || funct3 == core_pkg::f3_srl_sra) begin
          ctrl.imm = shamt_imm;
        end else begin
          ctrl.imm = imm_i;
        end
      end
      core_pkg::opc_load: begin
        ctrl.alu_src_imm = 1'b1; // address = rs1 + imm
        ctrl.imm = imm_i;
        ctrl.mem_re = 1'b1;
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = core_pkg::wb_load;
      end
      core_pkg::opc_store: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.imm = imm_s;
        ctrl.mem_we = 1'b1;
      end
      core_pkg::opc_branch: begin
        ctrl.is_branch = 1'b1;
        ctrl.target_imm = imm_b;
      end
      core_pkg::opc_jal: begin
        ctrl.is_jal = 1'b1;
        ctrl.target_imm = imm_j;
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = core_pkg::wb_pc_plus4; // link
      end
      core_pkg::opc_jalr: begin
        ctrl.is_jalr = 1'b1;
        ctrl.target_imm = imm_i;
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = core_pkg::wb_pc_plus4;
      end
      core_pkg::opc_lui: begin
        ctrl.imm = imm_u;
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = core_pkg::wb_imm;
      end
      core_pkg::opc_auipc: begin
        ctrl.target_imm = imm_u; // pc + imm from the pc adder
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = core_pkg::wb_pc_target;
      end
      core_pkg::opc_system: begin
        // ecall and ebreak retire as no-ops
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_lsu.sv
`default_nettype none

module rv_lsu (
  input  core_pkg::ctrl_t           ctrl,
  input  logic [core_pkg::xlen-1:0] addr,
  input  logic [core_pkg::xlen-1:0] store_data,
  input  logic [core_pkg::xlen-1:0] rdata,
  output core_pkg::dmem_req_t       req,
  output logic [core_pkg::xlen-1:0] load_data
);

  logic [1:0] lane;
  logic [3:0] mask;
  logic [7:0] rd_byte;
  logic [15:0] rd_half;

  assign lane = addr[1:0];

  // store data replicated so every lane holds the value
  always_comb begin
    req.addr = addr;
    req.we = ctrl.mem_we;
    req.re = ctrl.mem_re;
    case (ctrl.funct3)
      core_pkg::f3_byte: begin
        req.wdata = {4{store_data[7:0]}};
        mask = 4'b0001 << lane;
      end
      core_pkg::f3_half: begin
        req.wdata = {2{store_data[15:0]}};
        if (lane[0]) begin
          mask = 4'b0000; // odd address
        end else begin
          mask = lane[1] ? 4'b1100 : 4'b0011;
        end
      end
      core_pkg::f3_word: begin
        req.wdata = store_data;
        mask = (lane == 2'b00) ? 4'b1111 : 4'b0000;
      end
      default: begin
        req.wdata = store_data;
        mask = 4'b0000;
      end
    endcase
    req.wmask = ctrl.mem_we ? mask : 4'b0000;
  end

  // load side
  assign rd_byte = rdata[8*lane +: 8];
  assign rd_half = lane[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (ctrl.funct3)
      core_pkg::f3_byte:   load_data = {{24{rd_byte[7]}}, rd_byte};
      core_pkg::f3_byte_u: load_data = {24'h00_0000, rd_byte};
      core_pkg::f3_half:   load_data = lane[0] ? '0 : {{16{rd_half[15]}}, rd_half};
      core_pkg::f3_half_u: load_data = lane[0] ? '0 : {16'h0000, rd_half};
      core_pkg::f3_word:   load_data = (lane == 2'b00) ? rdata : '0;
      default:             load_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_regfile.sv
`default_nettype none

module rv_regfile (
  input  logic                            clk,
  input  logic                            we,
  input  logic [core_pkg::reg_addr_w-1:0] waddr,
  input  logic [core_pkg::xlen-1:0]       wdata,
  input  logic [core_pkg::reg_addr_w-1:0] raddr1,
  input  logic [core_pkg::reg_addr_w-1:0] raddr2,
  output logic [core_pkg::xlen-1:0]       rdata1,
  output logic [core_pkg::xlen-1:0]       rdata2
);

  logic [core_pkg::xlen-1:0] regs [core_pkg::num_regs];

  always_ff @(posedge clk) begin
    if (we && waddr != '0) begin // x0 stays untouched
      regs[waddr] <= wdata;
    end
  end

  // x0 is forced to zero on the read side
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: sim.f
design/core_pkg.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_branch_unit.sv
design/rv_regfile.sv
design/rv_lsu.sv
design/rv_core.sv
test/rv_core_properties.sv
test/tb_rv_core.sv

// File: test/rv_core_properties.sv
`default_nettype none

module rv_core_properties (
  input wire logic                      clk,
  input wire logic                      rst,
  input wire logic [core_pkg::xlen-1:0] pc,
  input wire core_pkg::dmem_req_t       dmem_req
);
  timeunit 1ns;
  timeprecision 100ps;

  a_no_we_and_re: assert property (@(posedge clk) disable iff (rst)
    !(dmem_req.we && dmem_req.re))
    else $error("load and store strobes set together");

  a_mask_needs_we: assert property (@(posedge clk) disable iff (rst)
    !dmem_req.we |-> dmem_req.wmask == 4'b0000)
    else $error("write mask set without a store");

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned");

  a_pc_after_rst: assert property (@(posedge clk) rst |=> pc == core_pkg::reset_pc)
    else $error("pc not at the reset vector after reset");

endmodule

bind rv_core rv_core_properties u_properties (
  .clk      (clk),
  .rst      (rst),
  .pc       (pc),
  .dmem_req (dmem_req)
);

`default_nettype wire

// File: test/tb_rv_core.sv
`default_nettype none

module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int prog_words = 400;
  localparam int cycle_limit = 10 + prog_words + 100;
  localparam logic [31:0] prog_end = core_pkg::reset_pc + 4 * prog_words;
  localparam logic [31:0] data_base = 32'h0001_0000; // 1 KiB window held in x31
  localparam logic [31:0] nop = 32'h0000_0013;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic [31:0] pc;
  logic [31:0] instr;
  core_pkg::dmem_req_t dmem_req;
  logic [31:0] dmem_rdata;

  logic [31:0] prog [prog_words];
  logic [31:0] dmem [256];
  logic [31:0] mdmem [256]; // model copy
  logic [31:0] mreg [32];
  logic loaded [32];      // register last written by a load
  logic [31:0] mpc;
  bit landing [prog_words + 16];
  int idx;
  int cycles;
  int checks [5];
  int errors [5];
  string names [5] = '{"reset", "control_flow", "alu", "stores", "loads"};

  rv_core UUT (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .instr      (instr),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] fetch(logic [31:0] a);
    if (a >= core_pkg::reset_pc && a < prog_end && a[1:0] == 2'b00) begin
      return prog[(a - core_pkg::reset_pc) >> 2];
    end
    return nop; // outside the program
  endfunction

  always @(posedge clk) begin
    #1;
    instr = fetch(pc);
  end

  assign dmem_rdata = dmem[dmem_req.addr[9:2]];

  always @(posedge clk) begin
    if (dmem_req.we && dmem_req.addr[31:10] == data_base[31:10]) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_req.wmask[i]) dmem[dmem_req.addr[9:2]][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
      end
    end
  end

  task automatic check_eq(int t, string what, logic [31:0] exp, logic [31:0] act);
    checks[t]++;
    if (exp !== act) begin
      errors[t]++;
      $display("ERR %s %s: expected %h, actual %h", names[t], what, exp, act);
    end
  endtask

  task automatic emit(logic [31:0] w);
    if (idx < prog_words) prog[idx] = w;
    idx++;
  endtask

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
    return {imm[11:5], rs2, 5'd31, f3, imm[4:0], 7'(core_pkg::opc_store)};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] o, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'(core_pkg::opc_branch)};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] o, logic [4:0] rd);
    return {o[20], o[10:1], o[11], o[19:12], rd, 7'(core_pkg::opc_jal)};
  endfunction

  task automatic build_program();
    int kind;
    int k;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [11:0] imm;
    logic [31:0] t;
    idx = 0;
    // lw x1, 0(x0) at the reset vector, so a load is decoded while rst is high
    emit(enc_i(12'h000, 5'd0, 3'd2, 5'd1, core_pkg::opc_load));
    emit({data_base[31:12], 5'd31, 7'(core_pkg::opc_lui)});
    for (int r = 1; r < 16; r++) begin // every used register gets a known value
      emit({20'($urandom), 5'(r), 7'(core_pkg::opc_lui)});
      emit(enc_i(12'($urandom), 5'(r), 3'd0, 5'(r), core_pkg::opc_op_imm));
    end
    while (idx < prog_words) begin
      kind = (prog_words - idx > 12) ? $urandom % 16 : $urandom % 10;
      rd = 5'($urandom % 16);
      rs1 = 5'($urandom % 16);
      rs2 = 5'($urandom % 16);
      f3 = 3'($urandom);
      k = 1 + $urandom % 8;
      case (kind)
        0, 1, 2, 3, 4: begin
          emit({((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2) ? 7'h20 : 7'h00,
                rs2, rs1, f3, rd, 7'(core_pkg::opc_op)});
        end
        5, 6, 7, 8: begin
          imm = 12'($urandom);
          if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
          if (f3 == 3'd5) imm = {1'b0, imm[10], 5'h00, imm[4:0]}; // srli or srai
          emit(enc_i(imm, rs1, f3, rd, core_pkg::opc_op_imm));
        end
        9: emit({20'($urandom), rd, ($urandom % 2) ? 7'(core_pkg::opc_lui)
                                                    : 7'(core_pkg::opc_auipc)});
        10: begin
          case ($urandom % 6)
            0: f3 = 3'd0;
            1: f3 = 3'd1;
            2: f3 = 3'd4;
            3: f3 = 3'd5;
            4: f3 = 3'd6;
            default: f3 = 3'd7;
          endcase
          landing[idx + k] = 1'b1;
          emit(enc_b(13'(4 * k), rs2, rs1, f3));
        end
        11: begin
          landing[idx + k] = 1'b1;
          emit(enc_j(21'(4 * k), rd));
        end
        12: begin
          // a jump into the middle would leave x30 stale
          if (!landing[idx + 1] && !landing[idx + 2]) begin
            t = core_pkg::reset_pc + 4 * (idx + 2 + k);
            landing[idx + 2 + k] = 1'b1;
            emit({t[31:12] + 20'(t[11]), 5'd30, 7'(core_pkg::opc_lui)});
            emit(enc_i(t[11:0], 5'd30, 3'd0, 5'd30, core_pkg::opc_op_imm));
            emit(enc_i(12'h000, 5'd30, 3'd0, rd, core_pkg::opc_jalr));
          end
        end
        13: begin
          case ($urandom % 5)
            0: f3 = 3'd0;
            1: f3 = 3'd1;
            2: f3 = 3'd2;
            3: f3 = 3'd4;
            default: f3 = 3'd5;
          endcase
          imm = 12'($urandom % 1024) & ~((12'd1 << f3[1:0]) - 12'd1);
          emit(enc_i(imm, 5'd31, f3, rd, core_pkg::opc_load));
          emit(enc_s(12'($urandom % 256) << 2, rd, 3'd2)); // store the loaded value back
        end
        default: begin
          f3 = 3'($urandom % 3);
          imm = 12'($urandom % 1024) & ~((12'd1 << f3[1:0]) - 12'd1);
          emit(enc_s(imm, rs2, f3));
        end
      endcase
    end
  endtask

  // executes one instruction of the model and checks the bus request the DUT shows for it
  task automatic step_model();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [31:0] next;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] w;
    logic [31:0] wdata;
    logic [3:0] mask;
    logic [2:0] f3;
    logic wr;
    logic cond;
    ins = fetch(mpc);
    f3 = ins[14:12];
    a = mreg[ins[19:15]];
    b = mreg[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    next = mpc + 4;
    wr = 1'b0;
    val = '0;
    check_eq(1, "pc", mpc, pc);
    check_eq(3, "we", 32'(ins[6:0] == core_pkg::opc_store), 32'(dmem_req.we));
    check_eq(4, "re", 32'(ins[6:0] == core_pkg::opc_load), 32'(dmem_req.re));
    case (ins[6:0])
      core_pkg::opc_op, core_pkg::opc_op_imm: begin
        if (ins[6:0] == core_pkg::opc_op_imm) b = imm_i;
        wr = 1'b1;
        case (f3)
          3'd0: val = (ins[6:0] == core_pkg::opc_op && ins[30]) ? a - b : a + b;
          3'd1: val = a << b[4:0];
          3'd2: val = 32'($signed(a) < $signed(b));
          3'd3: val = 32'(a < b);
          3'd4: val = a ^ b;
          3'd5: val = ins[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'd6: val = a | b;
          default: val = a & b;
        endcase
      end
      core_pkg::opc_lui: begin
        wr = 1'b1;
        val = {ins[31:12], 12'h000};
      end
      core_pkg::opc_auipc: begin
        wr = 1'b1;
        val = mpc + {ins[31:12], 12'h000};
      end
      core_pkg::opc_jal: begin
        wr = 1'b1;
        val = mpc + 4;
        next = mpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      core_pkg::opc_jalr: begin
        wr = 1'b1;
        val = mpc + 4;
        next = (a + imm_i) & ~32'd1;
      end
      core_pkg::opc_branch: begin
        case (f3)
          3'd0: cond = (a == b);
          3'd1: cond = (a != b);
          3'd4: cond = ($signed(a) < $signed(b));
          3'd5: cond = ($signed(a) >= $signed(b));
          3'd6: cond = (a < b);
          default: cond = (a >= b);
        endcase
        if (cond) next = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      core_pkg::opc_load: begin
        a = a + imm_i;
        w = mdmem[a[9:2]] >> (8 * a[1:0]);
        wr = 1'b1;
        case (f3)
          3'd0: val = {{24{w[7]}}, w[7:0]};
          3'd1: val = {{16{w[15]}}, w[15:0]};
          3'd4: val = {24'h0, w[7:0]};
          3'd5: val = {16'h0, w[15:0]};
          default: val = w;
        endcase
      end
      core_pkg::opc_store: begin
        a = a + imm_s;
        case (f3)
          3'd0: begin
            wdata = {4{b[7:0]}};
            mask = 4'b0001 << a[1:0];
          end
          3'd1: begin
            wdata = {2{b[15:0]}};
            mask = 4'b0011 << a[1:0];
          end
          default: begin
            wdata = b;
            mask = 4'b1111;
          end
        endcase
        check_eq(3, "store addr", a, dmem_req.addr);
        check_eq(3, "wmask", 32'(mask), 32'(dmem_req.wmask));
        check_eq(loaded[ins[24:20]] ? 4 : 2, "store data", wdata, dmem_req.wdata);
        for (int i = 0; i < 4; i++) begin
          if (mask[i]) mdmem[a[9:2]][8*i +: 8] = wdata[8*i +: 8];
        end
      end
      default: begin
      end
    endcase
    if (wr && ins[11:7] != 5'd0) begin
      mreg[ins[11:7]] = val;
      loaded[ins[11:7]] = (ins[6:0] == core_pkg::opc_load);
    end
    mpc = next;
  endtask

  always @(negedge clk) begin
    if (rst) begin
      if (pc !== 'x) begin // after the first reset edge
        check_eq(0, "strobes in reset", 32'd0, 32'({dmem_req.we, dmem_req.re}));
      end
    end else if (mpc < prog_end) begin
      step_model();
    end
  end

  initial begin
    int total_err;
    int total_chk;
    bit timed_out;
    void'($urandom(32'h4f2));
    instr = nop;
    mpc = core_pkg::reset_pc;
    cycles = 0;
    timed_out = 1'b0;
    for (int i = 0; i < 32; i++) begin
      mreg[i] = '0;
      loaded[i] = 1'b0;
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = (data_base + 4 * i) * 32'h9e37_79b9 ^ (data_base + 4 * i);
      mdmem[i] = dmem[i];
    end
    build_program();
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    check_eq(0, "pc after reset", core_pkg::reset_pc, pc);
    cycles = 10;
    while (pc < prog_end) begin
      @(posedge clk);
      cycles++;
      if (cycles >= cycle_limit) begin
        $display("the program did not finish within its cycle budget of %0d cycles",
                 cycle_limit);
        timed_out = 1'b1;
        break;
      end
    end
    @(negedge clk);
    total_err = 0;
    total_chk = 0;
    for (int t = 0; t < 5; t++) begin
      $display("test %s: %0d checks, %0d errors", names[t], checks[t], errors[t]);
      total_err += errors[t];
      total_chk += checks[t];
    end
    $display("%0d checks, %0d errors, %0d cycles", total_chk, total_err, cycles);
    if (!timed_out && total_err == 0 && checks[1] > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
